// File: common/rv_pipe_pkg.sv
`default_nettype none

package rv_pipe_pkg;

    localparam int NUM_REGS = 32;

    // bit positions in t_stage_vld
    localparam int STG_DE1 = 0;
    localparam int STG_RD1 = 1;
    localparam int STG_EX1 = 2;
    localparam int STG_MM1 = 3;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;  // selects SUB in the OP group

    typedef logic [31:0]         t_word;
    typedef logic [4:0]          t_reg_idx;
    typedef logic [NUM_REGS-1:0] t_reg_mask;  // bit n stands for xn
    typedef logic [3:0]          t_stage_vld;

    typedef enum logic [6:0] {
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011
    } t_opcode;

    typedef enum logic [2:0] {
        F3_ADD = 3'b000,
        F3_SLT = 3'b010,
        F3_XOR = 3'b100,
        F3_OR  = 3'b110,
        F3_AND = 3'b111
    } t_funct3;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_NOP
    } t_alu_op;

    typedef struct packed {
        t_alu_op  alu_op;
        t_reg_idx rs1;
        t_reg_idx rs2;
        t_reg_idx rd;
        logic     rs1_used;
        logic     rs2_used;
        logic     wr_en;     // never set for x0 or a NOP
        logic     use_imm;
        t_word    imm;       // sign-extended I-type immediate
    } t_uop;

    function automatic t_reg_mask uop_to_rdmask(t_uop uop);
        t_reg_mask mask;
        mask = '0;
        if (uop.rs1_used)
            mask[uop.rs1] = 1'b1;
        if (uop.rs2_used)
            mask[uop.rs2] = 1'b1;
        return mask;
    endfunction

    function automatic t_reg_mask uop_to_wrmask(t_uop uop);
        t_reg_mask mask;
        mask = '0;
        if (uop.wr_en)
            mask[uop.rd] = 1'b1;
        return mask;
    endfunction

endpackage

`default_nettype wire

// File: design/uop_decode.sv
`default_nettype none

module uop_decode (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire logic               de_load,
    input  wire rv_pipe_pkg::t_word instr,
    output rv_pipe_pkg::t_uop       de_uop
);

    import rv_pipe_pkg::*;

    logic [6:0] funct7;
    logic [2:0] funct3;
    t_alu_op    f3_op;
    t_uop       dec_uop;

    assign funct7 = instr[31:25];
    assign funct3 = instr[14:12];

    // funct3 picks the same operation for register and immediate forms
    always_comb begin
        case (t_funct3'(funct3))
            F3_ADD:  f3_op = ALU_ADD;
            F3_SLT:  f3_op = ALU_SLT;
            F3_XOR:  f3_op = ALU_XOR;
            F3_OR:   f3_op = ALU_OR;
            F3_AND:  f3_op = ALU_AND;
            default: f3_op = ALU_NOP;
        endcase
    end

    always_comb begin
        dec_uop        = '0;
        dec_uop.alu_op = ALU_NOP;
        dec_uop.rs1    = instr[19:15];
        dec_uop.rs2    = instr[24:20];
        dec_uop.rd     = instr[11:7];
        dec_uop.imm    = {{20{instr[31]}}, instr[31:20]};
        case (t_opcode'(instr[6:0]))
            OPC_OP: begin
                if (funct7 == F7_BASE)
                    dec_uop.alu_op = f3_op;
                else if (funct7 == F7_ALT && t_funct3'(funct3) == F3_ADD)
                    dec_uop.alu_op = ALU_SUB;
            end
            OPC_OP_IMM: begin
                dec_uop.alu_op  = f3_op;
                dec_uop.use_imm = 1'b1;
            end
            default: ;  // anything else stays a NOP that touches no register
        endcase
        dec_uop.rs1_used = (dec_uop.alu_op != ALU_NOP);
        dec_uop.rs2_used = (dec_uop.alu_op != ALU_NOP) && !dec_uop.use_imm;
        dec_uop.wr_en    = (dec_uop.alu_op != ALU_NOP) && (dec_uop.rd != '0);
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            de_uop <= '0;
        end else if (de_load) begin
            de_uop <= dec_uop;  // held as is while stall keeps de_load low
        end
    end

endmodule

`default_nettype wire

// File: design/scoreboard.sv
`default_nettype none

module scoreboard (
    input  wire rv_pipe_pkg::t_stage_vld stage_vld,
    input  wire rv_pipe_pkg::t_uop       de_uop,
    input  wire rv_pipe_pkg::t_uop       rd_uop,
    input  wire rv_pipe_pkg::t_uop       ex_uop,
    input  wire rv_pipe_pkg::t_uop       mm_uop,
    output logic                         stall
);

    import rv_pipe_pkg::*;

    t_reg_mask rdmask_de1;
    t_reg_mask wrmask_rd1;
    t_reg_mask wrmask_ex1;
    t_reg_mask wrmask_mm1;

    assign rdmask_de1 = uop_to_rdmask(de_uop);

    // bubbles and empty stages must not claim a destination
    assign wrmask_rd1 = uop_to_wrmask(rd_uop) & {NUM_REGS{stage_vld[STG_RD1]}};
    assign wrmask_ex1 = uop_to_wrmask(ex_uop) & {NUM_REGS{stage_vld[STG_EX1]}};
    assign wrmask_mm1 = uop_to_wrmask(mm_uop) & {NUM_REGS{stage_vld[STG_MM1]}};

    // no bypass, so any pending write to a source holds the DE1 uop
    assign stall = stage_vld[STG_DE1]
                 & |(rdmask_de1 & (wrmask_rd1 | wrmask_ex1 | wrmask_mm1));

endmodule

`default_nettype wire

// File: design/reg_file.sv
`default_nettype none

module reg_file (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire rv_pipe_pkg::t_reg_idx rs1,
    input  wire rv_pipe_pkg::t_reg_idx rs2,
    input  wire logic                  wr_en,
    input  wire rv_pipe_pkg::t_reg_idx wr_idx,
    input  wire rv_pipe_pkg::t_word    wr_data,
    output rv_pipe_pkg::t_word         rs1_data,
    output rv_pipe_pkg::t_word         rs2_data
);

    import rv_pipe_pkg::*;

    t_word regs [1:NUM_REGS-1];  // x0 has no storage

    always_ff @(posedge clk) begin
        if (rst_n && wr_en && wr_idx != '0) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // a write lands at the edge, a read in the same cycle sees the old value
    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

// File: design/alu_exec.sv
`default_nettype none

module alu_exec (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire rv_pipe_pkg::t_uop  de_uop,
    input  wire rv_pipe_pkg::t_word rs1_data,
    input  wire rv_pipe_pkg::t_word rs2_data,
    output rv_pipe_pkg::t_uop       rd_uop,
    output rv_pipe_pkg::t_uop       ex_uop,
    output rv_pipe_pkg::t_uop       mm_uop,
    output rv_pipe_pkg::t_reg_idx   wb_rd,
    output rv_pipe_pkg::t_word      wb_data
);

    import rv_pipe_pkg::*;

    typedef struct packed {
        t_uop  uop;
        t_word rs1_val;
        t_word rs2_val;
    } t_rd_pkt;

    typedef struct packed {
        t_uop  uop;
        t_word result;
    } t_ex_pkt;

    t_rd_pkt rd_q;
    t_ex_pkt ex_q;
    t_ex_pkt mm_q;
    t_word   op_b;
    t_word   alu_res;

    always_comb begin
        op_b = rd_q.uop.use_imm ? rd_q.uop.imm : rd_q.rs2_val;
        case (rd_q.uop.alu_op)
            ALU_ADD: alu_res = rd_q.rs1_val + op_b;
            ALU_SUB: alu_res = rd_q.rs1_val - op_b;
            ALU_AND: alu_res = rd_q.rs1_val & op_b;
            ALU_OR:  alu_res = rd_q.rs1_val | op_b;
            ALU_XOR: alu_res = rd_q.rs1_val ^ op_b;
            ALU_SLT: alu_res = t_word'($signed(rd_q.rs1_val) < $signed(op_b));
            default: alu_res = '0;
        endcase
    end

    // every stage moves each cycle, stall only turns the RD1 copy into a bubble
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_q.uop <= '0;
            ex_q.uop <= '0;
            mm_q.uop <= '0;
        end else begin
            rd_q <= '{uop: de_uop, rs1_val: rs1_data, rs2_val: rs2_data};
            ex_q <= '{uop: rd_q.uop, result: alu_res};
            mm_q <= ex_q;
        end
    end

    assign rd_uop  = rd_q.uop;
    assign ex_uop  = ex_q.uop;
    assign mm_uop  = mm_q.uop;
    assign wb_rd   = mm_q.uop.rd;
    assign wb_data = mm_q.result;

endmodule

`default_nettype wire

// File: design/pipe_ctrl.sv
`default_nettype none

module pipe_ctrl (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire logic               instr_valid,
    input  wire logic               stall,
    input  wire logic               mm_wr_en,
    output logic                    de_load,
    output rv_pipe_pkg::t_stage_vld stage_vld,
    output logic                    wb_valid
);

    import rv_pipe_pkg::*;

    t_stage_vld vld_q;

    // the source keeps its word up while stall is high, so it is taken later
    assign de_load = instr_valid & ~stall;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vld_q <= '0;
        end else begin
            vld_q[STG_DE1] <= de_load | (vld_q[STG_DE1] & stall);
            vld_q[STG_RD1] <= vld_q[STG_DE1] & ~stall;  // bubble on stall
            vld_q[STG_EX1] <= vld_q[STG_RD1];
            vld_q[STG_MM1] <= vld_q[STG_EX1];
        end
    end

    assign stage_vld = vld_q;
    assign wb_valid  = vld_q[STG_MM1] & mm_wr_en;

    // a stall with nothing in flight ahead of DE1 could never clear
    a_stall_has_producer: assert property (@(posedge clk) disable iff (!rst_n)
        stall |-> |stage_vld[STG_MM1:STG_RD1]);

endmodule

`default_nettype wire

// File: design/rv_pipe_top.sv
`default_nettype none

module rv_pipe_top (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire logic               instr_valid,
    input  wire rv_pipe_pkg::t_word instr,
    output logic                    stall,
    output logic                    wb_valid,
    output rv_pipe_pkg::t_reg_idx   wb_rd,
    output rv_pipe_pkg::t_word      wb_data
);

    import rv_pipe_pkg::*;

    logic       de_load;
    t_stage_vld stage_vld;
    t_uop       de_uop;
    t_uop       rd_uop;
    t_uop       ex_uop;
    t_uop       mm_uop;
    t_word      rs1_data;
    t_word      rs2_data;

    pipe_ctrl pipe_ctrl_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .stall       (stall),
        .mm_wr_en    (mm_uop.wr_en),
        .de_load     (de_load),
        .stage_vld   (stage_vld),
        .wb_valid    (wb_valid)
    );

    uop_decode uop_decode_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .de_load (de_load),
        .instr   (instr),
        .de_uop  (de_uop)
    );

    scoreboard scoreboard_i (
        .stage_vld (stage_vld),
        .de_uop    (de_uop),
        .rd_uop    (rd_uop),
        .ex_uop    (ex_uop),
        .mm_uop    (mm_uop),
        .stall     (stall)
    );

    // read ports follow DE1 so operands land in RD1 on the next edge
    reg_file reg_file_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1      (de_uop.rs1),
        .rs2      (de_uop.rs2),
        .wr_en    (wb_valid),
        .wr_idx   (wb_rd),
        .wr_data  (wb_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    alu_exec alu_exec_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .de_uop   (de_uop),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .rd_uop   (rd_uop),
        .ex_uop   (ex_uop),
        .mm_uop   (mm_uop),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data)
    );

    // RD1 to MM1 never stop, so the oldest producer leaves within three cycles
    a_stall_bounded: assert property (@(posedge clk) disable iff (!rst_n)
        stall [*3] |=> !stall);

endmodule

`default_nettype wire

// File: test/rv_pipe_tb.sv
`default_nettype none

module rv_pipe_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import rv_pipe_pkg::*;

    typedef enum int {R_NONE, R_ADD, R_SUB, R_AND, R_OR, R_XOR, R_SLT} t_ref_op;

    localparam int          NUM_RANDOM = 300;
    localparam int          NUM_INSTR  = NUM_RANDOM + 9;  // nine directed words come first
    localparam logic [31:0] LFSR_TAPS  = 32'h8020_0003;

    logic        clk;
    logic        rst_n;
    logic        instr_valid;
    t_word       instr;
    logic        stall;
    logic        wb_valid;
    t_reg_idx    wb_rd;
    t_word       wb_data;
    logic [31:0] lfsr_state;
    t_word       model_regs [NUM_REGS];
    t_reg_idx    exp_rd_q [$];
    t_word       exp_data_q [$];
    int          exp_due_q [$];   // cycle in which each write must show up
    t_word       de_word;         // stage model, a destination of x0 means no write
    logic        de_full;
    t_reg_idx    rd_dst;
    t_reg_idx    ex_dst;
    t_reg_idx    mm_dst;
    logic        last_wr;
    logic        any_accepted;
    int          cyc;
    int          value_errors;
    int          other_errors;
    int          writes_checked;

    rv_pipe_top rv_pipe_top_i (.*);

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] val;
        logic        out_bit;
        val = '0;
        for (int i = 0; i < n; i++) begin
            out_bit    = lfsr_state[0];
            lfsr_state = (lfsr_state >> 1) ^ (out_bit ? LFSR_TAPS : 32'd0);
            val        = {val[30:0], out_bit};
        end
        return val;
    endfunction

    function automatic t_ref_op ref_op(input t_word w);
        if (w[6:0] == 7'b0110011 && w[31:25] == 7'b0100000)
            return (w[14:12] == 3'b000) ? R_SUB : R_NONE;
        if (!(w[6:0] == 7'b0010011 || (w[6:0] == 7'b0110011 && w[31:25] == 7'd0)))
            return R_NONE;
        case (w[14:12])
            3'b000:  return R_ADD;
            3'b010:  return R_SLT;
            3'b100:  return R_XOR;
            3'b110:  return R_OR;
            3'b111:  return R_AND;
            default: return R_NONE;
        endcase
    endfunction

    // ISA result of a word against the register state that precedes it
    function automatic t_word ref_result(input t_word w);
        t_word a;
        t_word b;
        a = model_regs[w[19:15]];
        b = (w[6:0] == 7'b0010011) ? {{20{w[31]}}, w[31:20]} : model_regs[w[24:20]];
        case (ref_op(w))
            R_ADD:   return a + b;
            R_SUB:   return a - b;
            R_AND:   return a & b;
            R_OR:    return a | b;
            R_XOR:   return a ^ b;
            R_SLT:   return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: return '0;
        endcase
    endfunction

    function automatic t_reg_idx dest_of(input t_word w);
        return (ref_op(w) == R_NONE) ? 5'd0 : w[11:7];
    endfunction

    function automatic t_reg_mask reg_bit(input t_reg_idx r);
        return (r == 5'd0) ? t_reg_mask'(0) : (t_reg_mask'(1) << r);
    endfunction

    function automatic t_reg_mask src_mask(input t_word w);
        if (ref_op(w) == R_NONE)
            return t_reg_mask'(0);
        return reg_bit(w[19:15]) | ((w[6:0] == 7'b0010011) ? t_reg_mask'(0) : reg_bit(w[24:20]));
    endfunction

    // registers come from x0 to x7 so that hazards are frequent
    function automatic t_word gen_instr();
        logic [3:0] kind;
        t_reg_idx   rd;
        t_reg_idx   rs1;
        t_reg_idx   rs2;
        logic [2:0] f3;
        kind = 4'(take_bits(4));
        rd   = t_reg_idx'(take_bits(3));
        rs1  = t_reg_idx'(take_bits(3));
        rs2  = t_reg_idx'(take_bits(3));
        f3   = 3'(take_bits(3));  // three of the eight values are not supported
        case (kind)
            4'd0, 4'd1, 4'd2, 4'd3, 4'd4: return {7'd0, rs2, rs1, f3, rd, 7'b0110011};
            4'd5:  return {7'b0100000, rs2, rs1, 3'b000, rd, 7'b0110011};
            4'd12: return {7'b0100000, rs2, rs1, 3'b111, rd, 7'b0110011};
            4'd13, 4'd14, 4'd15: return {20'(take_bits(20)), rd, 7'b0110111};  // LUI
            default: return {12'(take_bits(12)), rs1, f3, rd, 7'b0010011};
        endcase
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        value_errors++;
        $display("CHECK FAILED at %0t: %s is %0h, expected %0h", $time, name, got, exp);
    endtask

    // checks the cycle that has just settled, before new inputs go out
    task automatic observe();
        logic exp_stall;
        int   last;
        cyc++;
        if (wb_valid && exp_rd_q.size() == 0) begin
            other_errors++;
            $display("write to x%0d at %0t while no write was pending", wb_rd, $time);
        end else if (wb_valid) begin
            assert (wb_rd == exp_rd_q[0])
                else report_mismatch("wb_rd", 32'(wb_rd), 32'(exp_rd_q[0]));
            assert (wb_data == exp_data_q[0])
                else report_mismatch("wb_data", wb_data, exp_data_q[0]);
            assert (cyc == exp_due_q[0])
                else report_mismatch("wb_valid cycle", cyc, exp_due_q[0]);
            void'(exp_rd_q.pop_front());
            void'(exp_data_q.pop_front());
            void'(exp_due_q.pop_front());
            writes_checked++;
        end
        exp_stall = de_full && ((src_mask(de_word)
                  & (reg_bit(rd_dst) | reg_bit(ex_dst) | reg_bit(mm_dst))) != t_reg_mask'(0));
        assert (stall == exp_stall) else report_mismatch("stall", 32'(stall), 32'(exp_stall));
        last = exp_due_q.size() - 1;
        if (stall && last_wr && last >= 0)
            exp_due_q[last] = exp_due_q[last] + 1;  // the held writer leaves one cycle later
    endtask

    // presents one cycle of input and moves the stage model across the next edge
    task automatic drive(input logic valid, input t_word word);
        logic  accept;
        t_word res;
        instr_valid = valid;
        instr       = word;
        accept      = valid && !stall;
        mm_dst      = ex_dst;
        ex_dst      = rd_dst;
        rd_dst      = (de_full && !stall) ? dest_of(de_word) : 5'd0;
        if (accept) begin
            de_word      = word;
            any_accepted = 1'b1;
            last_wr      = (dest_of(word) != 5'd0);
            if (last_wr) begin
                res = ref_result(word);
                exp_rd_q.push_back(dest_of(word));
                exp_data_q.push_back(res);
                exp_due_q.push_back(cyc + 4);
                model_regs[dest_of(word)] = res;
            end
        end
        de_full = accept || (de_full && stall);
    endtask

    task automatic issue(input t_word word);
        logic taken;
        taken = 1'b0;
        while (!taken) begin
            @(negedge clk);
            observe();
            taken = !stall;
            drive(1'b1, word);  // the same word stays up while stall is high
        end
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(negedge clk);
            observe();
            drive(1'b0, '0);
        end
    endtask

    a_quiet_start: assert property (@(posedge clk) disable iff (!rst_n)
        !any_accepted |-> (!stall && !wb_valid))
        else begin
            other_errors++;
            $display("stall or wb_valid high at %0t before any instruction", $time);
        end

    a_no_x0_write: assert property (@(posedge clk) disable iff (!rst_n)
        wb_valid |-> (wb_rd != 5'd0))
        else begin
            other_errors++;
            $display("write strobe for x0 at %0t", $time);
        end

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        #(5 * NUM_INSTR * 10);
        $display("watchdog expired at %0t, the pipeline stopped making progress", $time);
        $display("Test failures found");
        $finish;
    end

    initial begin
        rst_n          = 1'b0;
        instr_valid    = 1'b0;
        instr          = '0;
        lfsr_state     = 32'd81455;
        de_word        = '0;
        de_full        = 1'b0;
        rd_dst         = '0;
        ex_dst         = '0;
        mm_dst         = '0;
        last_wr        = 1'b0;
        any_accepted   = 1'b0;
        cyc            = 0;
        value_errors   = 0;
        other_errors   = 0;
        writes_checked = 0;
        for (int r = 0; r < NUM_REGS; r++)
            model_regs[r] = '0;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        idle(3);
        issue({12'd5, 5'd0, 3'b000, 5'd1, 7'b0010011});  // ADDI x1 into an empty pipeline
        idle(6);
        for (int r = 1; r < 8; r++)
            issue({12'(r * 37 - 100), 5'd0, 3'b000, 5'(r), 7'b0010011});
        issue({7'd0, 5'd2, 5'd1, 3'b000, 5'd0, 7'b0110011});  // ADD to x0 writes nothing
        idle(6);
        for (int n = 0; n < NUM_RANDOM; n++) begin
            if (3'(take_bits(3)) == 3'd0)
                idle(1);
            issue(gen_instr());
        end
        while (exp_rd_q.size() != 0)
            idle(1);
        idle(6);
        $display("%0d value mismatches, %0d other errors, %0d writes checked",
                 value_errors, other_errors, writes_checked);
        if (value_errors == 0 && other_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: rv_pipe_top.f
common/rv_pipe_pkg.sv
design/uop_decode.sv
design/scoreboard.sv
design/reg_file.sv
design/alu_exec.sv
design/pipe_ctrl.sv
design/rv_pipe_top.sv
test/rv_pipe_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/100ps \
    -f rv_pipe_top.f --top-module rv_pipe_tb -Mdir obj_dir
sim_out=$(./obj_dir/Vrv_pipe_tb)
printf '%s\n' "$sim_out"
printf '%s\n' "$sim_out" | grep -q "All tests passed!"
